// ==== design/led_matrix_pkg.sv ====
package led_matrix_pkg;

    localparam int panel_width   = 16;   // Columns per row
    localparam int panel_height  = 8;
    localparam int half_height   = 4;    // Rows r and r+4 are driven together
    localparam int frame_bytes   = 256;  // Two bytes per pixel
    localparam int plane_count   = 4;    // BCM bit-planes
    localparam int column_cycles = 8;    // clk_root cycles per shifted column
    localparam int display_unit  = 16;   // OE cycles for plane 0

    localparam logic [7:0] cmd_load   = 8'h4c;  // "L"
    localparam logic [7:0] cmd_enable = 8'h45;  // "E"

    // Byte view, as the loader writes it
    typedef struct packed {
        logic [7:0] high;
        logic [7:0] low;
    } pixel_bytes_t;

    // RGB565 view, as fetch decodes it
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_rgb_t;

    typedef union packed {
        pixel_bytes_t bytes;
        pixel_rgb_t   rgb;
    } pixel_word_t;

    // Colour triples are red in bit 2, blue in bit 0
    typedef struct packed {
        logic [2:0]                       rgb_top;
        logic [2:0]                       rgb_bottom;
        logic [$clog2(half_height)-1:0]   row_addr;
        logic                             clk_pixel;
        logic                             latch;
        logic                             oe;
        logic                             spare;  // Always 0
    } hub75_t;

    typedef struct packed {
        logic [$clog2(panel_width)-1:0]  column;
        logic [$clog2(half_height)-1:0]  row;
        logic [$clog2(plane_count)-1:0]  plane;
    } scan_pos_t;

endpackage

// ==== design/frame_loader.sv ====
module frame_loader (
    input  logic       clk_root,
    input  logic       reset,
    input  logic       in_req,
    input  logic [7:0] in_data,
    output logic       in_ack,
    output logic       ram_we,
    output logic [7:0] ram_addr,
    output logic [7:0] ram_wdata,
    output logic [2:0] rgb_enable,
    output logic [3:0] plane_enable
);
    import led_matrix_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_enable,
        st_load
    } load_state_t;

    load_state_t state;
    logic [7:0]  byte_count;
    logic        take;

    // New request not yet acknowledged, byte is valid now
    assign take = in_req && !in_ack;

    // Ack follows req with one cycle of delay
    always_ff @(posedge clk_root) begin
        if (reset) begin
            in_ack <= 1'b0;
        end else begin
            in_ack <= in_req;
        end
    end

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state        <= st_idle;
            byte_count   <= '0;
            rgb_enable   <= '1;  // Everything shown after reset
            plane_enable <= '1;
        end else if (take) begin
            case (state)
                st_idle: begin
                    byte_count <= '0;
                    if (in_data == cmd_load) begin
                        state <= st_load;
                    end else if (in_data == cmd_enable) begin
                        state <= st_enable;
                    end
                    // Anything else is dropped
                end
                st_enable: begin
                    rgb_enable   <= in_data[2:0];
                    plane_enable <= in_data[6:3];  // Plane 0 in bit 3
                    state        <= st_idle;
                end
                st_load: begin
                    byte_count <= byte_count + 8'd1;
                    if (byte_count == 8'(frame_bytes - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Write goes out in the same cycle the byte is taken
    assign ram_we    = take && (state == st_load);
    assign ram_addr  = byte_count;  // High byte first, so even address = high
    assign ram_wdata = in_data;

endmodule

// ==== design/framebuffer_ram.sv ====
module framebuffer_ram (
    input  logic                      clk_root,
    input  logic                      wr_en,
    input  logic [7:0]                wr_addr,
    input  logic [7:0]                wr_data,
    input  logic [6:0]                rd_addr,
    output led_matrix_pkg::pixel_word_t rd_data
);
    import led_matrix_pkg::*;

    // One lane per byte of the pixel word
    logic [7:0] mem_high [panel_width * panel_height];
    logic [7:0] mem_low  [panel_width * panel_height];

    // Port a, byte writes
    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            if (wr_addr[0]) begin
                mem_low[wr_addr[7:1]] <= wr_data;
            end else begin
                mem_high[wr_addr[7:1]] <= wr_data;
            end
        end
    end

    // Port b, registered word read
    // Same-cycle write to the same word returns the old value
    always_ff @(posedge clk_root) begin
        rd_data.bytes.high <= mem_high[rd_addr];
        rd_data.bytes.low  <= mem_low[rd_addr];
    end

endmodule

// ==== design/framebuffer_fetch.sv ====
module framebuffer_fetch (
    input  logic                        clk_root,
    input  logic                        reset,
    input  logic                        pixel_load,
    input  led_matrix_pkg::scan_pos_t   pos,
    input  logic [2:0]                  rgb_enable,
    input  logic [3:0]                  plane_enable,
    output logic [6:0]                  rd_addr,
    input  led_matrix_pkg::pixel_word_t rd_data,
    output logic [2:0]                  rgb_top,
    output logic [2:0]                  rgb_bottom
);
    import led_matrix_pkg::*;

    scan_pos_t   cur_pos;   // Position captured at pixel_load
    logic [2:0]  step;      // One-hot, cycles 1 to 3 of the column
    pixel_word_t top_word;
    logic [2:0]  enable_mask;

    // Top four bits of each channel, plane 0 is the lowest of them
    function automatic logic [2:0] plane_bits(pixel_word_t px, logic [1:0] plane);
        logic [2:0] bits;
        bits[2] = px.rgb.red[3'(plane) + 3'd1];
        bits[1] = px.rgb.green[3'(plane) + 3'd2];
        bits[0] = px.rgb.blue[3'(plane) + 3'd1];
        return bits;
    endfunction

    always_ff @(posedge clk_root) begin
        if (reset) begin
            step <= '0;
        end else begin
            step <= {step[1:0], pixel_load};
        end
    end

    always_ff @(posedge clk_root) begin
        if (pixel_load) begin
            cur_pos <= pos;
        end
    end

    // Cycle 1 top row, cycle 2 bottom row (row + 4)
    assign rd_addr = {step[1], cur_pos.row, cur_pos.column};

    assign enable_mask = rgb_enable & {3{plane_enable[cur_pos.plane]}};

    always_ff @(posedge clk_root) begin
        if (step[1]) begin
            top_word <= rd_data;  // Top pixel arrives in cycle 2
        end
        if (step[2]) begin
            // Bottom pixel arrives in cycle 3, both triples valid from cycle 4
            rgb_top    <= plane_bits(top_word, cur_pos.plane) & enable_mask;
            rgb_bottom <= plane_bits(rd_data, cur_pos.plane) & enable_mask;
        end
    end

endmodule

// ==== design/matrix_scan.sv ====
module matrix_scan (
    input  logic                      clk_root,
    input  logic                      reset,
    input  logic [2:0]                rgb_top,
    input  logic [2:0]                rgb_bottom,
    output led_matrix_pkg::scan_pos_t pos,
    output logic                      pixel_load,
    output led_matrix_pkg::hub75_t    panel
);
    import led_matrix_pkg::*;

    localparam int disp_width = $clog2(display_unit << (plane_count - 1));

    typedef enum logic [1:0] {
        st_shift,
        st_blank,
        st_latch,
        st_display
    } scan_state_t;

    scan_state_t                      state;
    logic [$clog2(column_cycles)-1:0] phase;
    logic [$clog2(panel_width)-1:0]   cur_column;
    logic [$clog2(half_height)-1:0]   cur_row;
    logic [$clog2(plane_count)-1:0]   cur_plane;
    logic [$clog2(half_height)-1:0]   row_addr;
    logic [disp_width-1:0]            disp_count;
    logic [disp_width-1:0]            disp_last;
    logic                             phase_last;

    assign phase_last = (phase == $bits(phase)'(column_cycles - 1));
    assign disp_last  = disp_width'((display_unit << cur_plane) - 1);  // BCM weight

    always_ff @(posedge clk_root) begin
        if (reset) begin
            state      <= st_shift;
            phase      <= '0;
            cur_column <= '0;
            cur_row    <= '0;
            cur_plane  <= '0;
            row_addr   <= '0;
            disp_count <= '0;
        end else begin
            case (state)
                st_shift: begin
                    phase <= phase + 1'b1;
                    if (phase_last) begin
                        phase      <= '0;
                        cur_column <= cur_column + 1'b1;
                        if (cur_column == $bits(cur_column)'(panel_width - 1)) begin
                            state <= st_blank;
                        end
                    end
                end
                st_blank: begin
                    state    <= st_latch;
                    row_addr <= cur_row;  // Visible from the latch cycle
                end
                st_latch: begin
                    state      <= st_display;
                    disp_count <= '0;
                end
                st_display: begin
                    disp_count <= disp_count + 1'b1;
                    if (disp_count == disp_last) begin
                        state     <= st_shift;
                        cur_plane <= cur_plane + 1'b1;  // Plane is the inner loop
                        if (cur_plane == $bits(cur_plane)'(plane_count - 1)) begin
                            cur_row <= cur_row + 1'b1;
                        end
                    end
                end
                default: state <= st_shift;
            endcase
        end
    end

    assign pos = '{column: cur_column, row: cur_row, plane: cur_plane};

    assign pixel_load = (state == st_shift) && (phase == '0);

    // Pixel clock high in the last two cycles, after fetch has settled
    always_comb begin
        panel.rgb_top    = rgb_top;
        panel.rgb_bottom = rgb_bottom;
        panel.row_addr   = row_addr;
        panel.clk_pixel  = (state == st_shift) && (phase >= $bits(phase)'(column_cycles - 2));
        panel.latch      = (state == st_latch);
        panel.oe         = (state == st_display);
        panel.spare      = 1'b0;
    end

endmodule

// ==== design/led_matrix_top.sv ====
module led_matrix_top (
    input  logic                   clk_root,
    input  logic                   reset,
    input  logic                   in_req,
    input  logic [7:0]             in_data,
    output logic                   in_ack,
    output led_matrix_pkg::hub75_t panel
);
    import led_matrix_pkg::*;

    logic        ram_we;
    logic [7:0]  ram_addr;
    logic [7:0]  ram_wdata;
    logic [6:0]  rd_addr;
    pixel_word_t rd_data;
    logic [2:0]  rgb_enable;
    logic [3:0]  plane_enable;
    scan_pos_t   pos;
    logic        pixel_load;
    logic [2:0]  rgb_top;
    logic [2:0]  rgb_bottom;

    frame_loader frame_loader_i (
        .clk_root     (clk_root),
        .reset        (reset),
        .in_req       (in_req),
        .in_data      (in_data),
        .in_ack       (in_ack),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable)
    );

    framebuffer_ram framebuffer_ram_i (
        .clk_root (clk_root),
        .wr_en    (ram_we),
        .wr_addr  (ram_addr),
        .wr_data  (ram_wdata),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    framebuffer_fetch framebuffer_fetch_i (
        .clk_root     (clk_root),
        .reset        (reset),
        .pixel_load   (pixel_load),
        .pos          (pos),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom)
    );

    matrix_scan matrix_scan_i (
        .clk_root   (clk_root),
        .reset      (reset),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .pos        (pos),
        .pixel_load (pixel_load),
        .panel      (panel)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_root,
    output logic reset
);

    initial begin
        clk_root = 1'b0;
        forever #10 clk_root = ~clk_root;  // Period 20
    end

    // Held for 8 rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk_root);
        @(negedge clk_root);
        reset <= 1'b0;
    end

endmodule

// ==== tb/led_matrix_sva.sv ====
module led_matrix_sva (
    input logic                   clk_root,
    input logic                   reset,
    input logic                   in_req,
    input logic                   in_ack,
    input led_matrix_pkg::hub75_t panel
);
    import led_matrix_pkg::*;

    // Ack only ever follows a request
    ack_follows_req: assert property (
        @(posedge clk_root) disable iff (reset)
        $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose without in_req");

    // Rows are latched only while the panel is blanked
    latch_while_blank: assert property (
        @(posedge clk_root) disable iff (reset)
        !(panel.latch && panel.oe)
    ) else $error("latch high while oe high");

    shift_while_blank: assert property (
        @(posedge clk_root) disable iff (reset)
        !(panel.clk_pixel && panel.oe)
    ) else $error("clk_pixel high while oe high");

endmodule

// ==== tb/led_matrix_tb.sv ====
module led_matrix_tb;
    import led_matrix_pkg::*;

    localparam int latch_timeout = 300;  // Longest shift plus display is 258 cycles
    localparam int ack_timeout   = 20;
    localparam int reset_timeout = 50;

    logic        clk_root;
    logic        reset;
    logic        in_req;
    logic [7:0]  in_data;
    logic        in_ack;
    hub75_t      panel;

    logic [31:0] lfsr_state = 32'h8fa4;
    logic [15:0] model_frame [panel_width * panel_height];  // RGB565 per pixel
    logic [2:0]  model_rgb_en = '1;
    logic [3:0]  model_plane_en = '1;
    logic        checking = 1'b0;
    int          latch_count = 0;  // Latch pulses seen since reset
    int          col_count = 0;
    int          disp_count = 0;
    int          disp_plane = 0;
    hub75_t      prev_panel = '0;
    int          column_checks = 0;
    int          expected_checks = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;

    tb_clock_gen clock_gen_i (
        .clk_root (clk_root),
        .reset    (reset)
    );

    led_matrix_top led_matrix_top_i (
        .clk_root (clk_root),
        .reset    (reset),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .panel    (panel)
    );

    bind led_matrix_top led_matrix_sva led_matrix_sva_i (.*);

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Red bits 12..15, green 7..10, blue 1..4 of the word give planes 0..3
    function automatic logic [2:0] expected_bits(input logic [15:0] px, input int plane);
        logic [2:0] bits;
        bits = {px[12 + plane], px[7 + plane], px[1 + plane]};
        return bits & model_rgb_en & {3{model_plane_en[plane]}};
    endfunction

    task automatic check_idle();
        if ({panel.oe, panel.latch, panel.clk_pixel, in_ack} !== 4'b0) begin
            $display("Mismatch {oe,latch,clk_pixel,in_ack}: got %h expected 0",
                     {panel.oe, panel.latch, panel.clk_pixel, in_ack});
            mismatch_count++;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        int gap;
        int wait_count;
        gap = int'(random_bits(2));
        repeat (gap) @(negedge clk_root);
        in_data    = value;
        in_req     = 1'b1;
        wait_count = 0;
        while (!in_ack && wait_count < ack_timeout) begin
            @(negedge clk_root);
            wait_count++;
        end
        if (!in_ack) begin
            $display("No in_ack for byte %h within %0d cycles", value, ack_timeout);
            failure_count++;
        end
        in_req     = 1'b0;
        wait_count = 0;
        while (in_ack && wait_count < ack_timeout) begin
            @(negedge clk_root);
            wait_count++;
        end
        if (in_ack) begin
            $display("in_ack stayed high after in_req fell");
            failure_count++;
        end
    endtask

    task automatic load_frame();
        logic [7:0] value;
        send_byte(cmd_load);
        for (int i = 0; i < frame_bytes; i++) begin
            value = 8'(random_bits(8));
            send_byte(value);
            if (i % 2 == 0) begin
                model_frame[i / 2][15:8] = value;  // High byte first
            end else begin
                model_frame[i / 2][7:0] = value;
            end
        end
    endtask

    task automatic set_enables(input logic [7:0] value);
        send_byte(cmd_enable);
        send_byte(value);
        model_rgb_en   = value[2:0];
        model_plane_en = value[6:3];
    endtask

    task automatic wait_latches(input int count);
        int target;
        int wait_count;
        target     = latch_count + count;
        wait_count = 0;
        while (latch_count < target && wait_count < latch_timeout * count) begin
            @(negedge clk_root);
            wait_count++;
        end
        if (latch_count < target) begin
            $display("Timed out waiting for %0d latch pulses", count);
            failure_count++;
        end
    endtask

    // Start at a latch so the next shift is read from the current frame
    task automatic check_scans(input int scans);
        wait_latches(1);
        checking <= 1'b1;
        expected_checks += scans * half_height * plane_count * panel_width;
        wait_latches(scans * half_height * plane_count);
        checking <= 1'b0;
    endtask

    // Panel monitor sampled on the falling edge where outputs are settled
    always @(negedge clk_root) begin : panel_monitor
        int         row;
        int         plane;
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        if (reset) begin
            latch_count <= 0;
            col_count  = 0;
            disp_count = 0;
            prev_panel = '0;
        end else begin
            row   = (latch_count / plane_count) % half_height;
            plane = latch_count % plane_count;
            if (panel.spare !== 1'b0) begin
                $display("Mismatch spare: got %h expected 0", panel.spare);
                mismatch_count++;
            end
            if (panel.clk_pixel && !prev_panel.clk_pixel) begin
                if (checking) begin
                    exp_top    = expected_bits(model_frame[row * panel_width + col_count], plane);
                    exp_bottom = expected_bits(
                        model_frame[(row + half_height) * panel_width + col_count], plane);
                    if (panel.rgb_top !== exp_top) begin
                        $display(
                            "Mismatch rgb_top: got %h expected %h (row %0d col %0d plane %0d)",
                            panel.rgb_top, exp_top, row, col_count, plane);
                        mismatch_count++;
                    end
                    if (panel.rgb_bottom !== exp_bottom) begin
                        $display(
                            "Mismatch rgb_bottom: got %h expected %h (row %0d col %0d plane %0d)",
                            panel.rgb_bottom, exp_bottom, row, col_count, plane);
                        mismatch_count++;
                    end
                    column_checks++;
                end
                col_count++;
            end
            if (panel.latch && !prev_panel.latch) begin
                if (col_count != panel_width) begin
                    $display("Latch came after %0d pixel clocks instead of %0d",
                             col_count, panel_width);
                    failure_count++;
                end
                if (panel.row_addr !== 2'(row)) begin
                    $display("Mismatch row_addr: got %h expected %h", panel.row_addr, 2'(row));
                    mismatch_count++;
                end
                disp_plane = plane;
                col_count  = 0;
                latch_count <= latch_count + 1;
            end
            if (panel.oe) begin
                disp_count++;
            end
            if (prev_panel.oe && !panel.oe) begin
                if (disp_count != (display_unit << disp_plane)) begin  // BCM weight
                    $display("Mismatch oe cycles: got %h expected %h",
                             disp_count, display_unit << disp_plane);
                    mismatch_count++;
                end
                disp_count = 0;
            end
            prev_panel = panel;
        end
    end

    initial begin
        int wait_count;
        in_req     = 1'b0;
        in_data    = 8'h00;
        wait_count = 0;
        @(negedge clk_root);
        while (reset && wait_count < reset_timeout) begin
            check_idle();
            @(negedge clk_root);
            wait_count++;
        end
        if (reset) begin
            $display("Reset was never released");
            failure_count++;
        end
        check_idle();  // First cycle out of reset

        load_frame();
        check_scans(2);

        set_enables(8'(random_bits(7)));
        check_scans(1);

        // Reload with all enables back on
        set_enables(8'h7f);
        load_frame();
        check_scans(1);

        if (column_checks != expected_checks) begin
            $display("Checked %0d pixel columns, expected %0d", column_checks, expected_checks);
            failure_count++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== led_matrix.f ====
design/led_matrix_pkg.sv
design/frame_loader.sv
design/framebuffer_ram.sv
design/framebuffer_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
tb/tb_clock_gen.sv
tb/led_matrix_sva.sv
tb/led_matrix_tb.sv

// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - files:
      - design/led_matrix_pkg.sv
      - design/frame_loader.sv
      - design/framebuffer_ram.sv
      - design/framebuffer_fetch.sv
      - design/matrix_scan.sv
      - design/led_matrix_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/led_matrix_sva.sv
      - tb/led_matrix_tb.sv
